// ==== compile.f ====
+incdir+rtl
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/memBus.sv
rtl/instRom.sv
rtl/decoder.sv
rtl/alu.sv
rtl/regFile.sv
rtl/mmio.sv
rtl/cpu.sv
verification/cpuTb.sv

// ==== prog.hex ====
// one RV32I instruction word per line, word address 0 first
000020B7 // 00 lui  x1, 0x2        I/O base 0x2000
00500113 // 04 addi x2, x0, 5
00710193 // 08 addi x3, x2, 7
00219213 // 0C slli x4, x3, 2
402202B3 // 10 sub  x5, x4, x2
0032C333 // 14 xor  x6, x5, x3
0060A223 // 18 sw   x6, 4(x1)      SEG
00000393 // 1C addi x7, x0, 0
00300413 // 20 addi x8, x0, 3
00938393 // 24 addi x7, x7, 9      loop body
FFF40413 // 28 addi x8, x8, -1
FE041CE3 // 2C bne  x8, x0, -8
0070A223 // 30 sw   x7, 4(x1)      SEG
00000663 // 34 beq  x0, x0, +12
0040A223 // 38 sw   x4, 4(x1)      squashed
0040A223 // 3C sw   x4, 4(x1)      squashed
0080C483 // 40 lbu  x9, 8(x1)      SWT
00908023 // 44 sb   x9, 0(x1)      LED
00808503 // 48 lb   x10, 8(x1)     SWT
00A0A223 // 4C sw   x10, 4(x1)     SEG
00C0A583 // 50 lw   x11, 12(x1)    KB poll
1005F593 // 54 andi x11, x11, 256
FE058CE3 // 58 beq  x11, x0, -8
00C0C603 // 5C lbu  x12, 12(x1)    KB
00C0A223 // 60 sw   x12, 4(x1)     SEG
00100073 // 64 ebreak

// ==== rtl/alu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational ALU, shifts use b[4:0]
// compare ops give 1 or 0, used as branch taken
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpuParams.svh"

module alu (
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	input isaPkg::aluOpT op,
	output logic [`XLEN-1:0] result
);
	import isaPkg::*;

	logic [4:0] shamt;
	logic lt;
	logic ltu;
	logic eq;

	assign shamt = b[4:0];
	// shared by slt/sltu and the branches
	assign lt = $signed(a) < $signed(b);
	assign ltu = a < b;
	assign eq = a == b;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_SLL: result = a << shamt;
			ALU_SLT, ALU_LT: result = `XLEN'(lt);
			ALU_SLTU, ALU_LTU: result = `XLEN'(ltu);
			ALU_XOR: result = a ^ b;
			ALU_SRL: result = a >> shamt;
			ALU_SRA: result = $signed(a) >>> shamt;
			ALU_OR: result = a | b;
			ALU_AND: result = a & b;
			ALU_EQ: result = `XLEN'(eq);
			ALU_NE: result = `XLEN'(!eq);
			ALU_GE: result = `XLEN'(!lt);
			default: result = `XLEN'(!ltu);
		endcase
	end
endmodule

// ==== rtl/cpu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// five-stage in-order RV32I core, never stalls
// forwarding into ID, plus load data into EX
// taken branches and jumps resolve in EX, two bubbles
// ebreak in WB freezes the whole pipeline for good
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpuParams.svh"

module cpu (
	input logic clk,
	input logic rst,
	input logic [7:0] swtData,
	input logic [7:0] kbData,
	input logic kbReady,
	output logic [`XLEN-1:0] pcIf,
	output logic [`XLEN-1:0] pcWb,
	output logic retire,
	output logic halt,
	output logic notImpl,
	output logic kbRead,
	output logic [`LED_W-1:0] ledData,
	output logic [`XLEN-1:0] segData
);
	import pipePkg::*;

	logic halting;
	logic takeJump;
	logic [`XLEN-1:0] jumpTarget;
	logic [`XLEN-1:0] ifInst;
	logic idValid;
	logic [`XLEN-1:0] idPc;
	logic [`XLEN-1:0] idInst;
	logic [`REG_ADDR_W-1:0] idRd;
	logic [`REG_ADDR_W-1:0] idRs1;
	logic [`REG_ADDR_W-1:0] idRs2;
	logic [`XLEN-1:0] idImm;
	logic [`XLEN-1:0] rfData1;
	logic [`XLEN-1:0] rfData2;
	ctrlT idCtrl;
	exPayloadT idOut;
	exPayloadT ex;
	logic exValid;
	ctrlT exCtrl;
	logic [`XLEN-1:0] exRs1;
	logic [`XLEN-1:0] exRs2;
	logic [`XLEN-1:0] exA;
	logic [`XLEN-1:0] exB;
	logic [`XLEN-1:0] aluResult;
	logic [`XLEN-1:0] exWrData;
	memPayloadT exOut;
	memPayloadT mem;
	logic memValid;
	ctrlT memCtrl;
	logic [`XLEN-1:0] memWrData;
	wbPayloadT memOut;
	wbPayloadT wb;
	logic wbValid;
	ctrlT wbCtrl;
	logic [`XLEN-1:0] wbWrData;

	memBus dbus();

	// youngest in-flight writer wins, WB comes through the regfile bypass
	function automatic logic [`XLEN-1:0] fwdId(
		input logic [`REG_ADDR_W-1:0] rs,
		input logic [`XLEN-1:0] rfData
	);
		if (exCtrl.regWen && ex.rd == rs)
			return exWrData;
		if (memCtrl.regWen && mem.rd == rs)
			return memWrData;
		return rfData;
	endfunction

	// squashed or empty slots act as all-zero control
	assign exCtrl = exValid ? ex.ctrl : '0;
	assign memCtrl = memValid ? mem.ctrl : '0;
	assign wbCtrl = wbValid ? wb.ctrl : '0;
	// freeze already in the cycle ebreak sits in WB
	assign halting = halt || wbCtrl.isEbreak;

	// IF
	instRom rom (.pc(pcIf), .inst(ifInst));

	// ID
	decoder dec (
		.inst(idInst), .rd(idRd), .rs1(idRs1), .rs2(idRs2), .imm(idImm), .ctrl(idCtrl)
	);

	regFile rf (
		.clk(clk), .rst(rst), .wen(wbCtrl.regWen), .rd(wb.rd),
		.rs1(idRs1), .rs2(idRs2), .wdata(wbWrData),
		.rdata1(rfData1), .rdata2(rfData2)
	);

	always_comb begin
		idOut.pc = idPc;
		idOut.imm = idImm;
		idOut.rd = idRd;
		idOut.ctrl = idCtrl;
		idOut.rs1Data = fwdId(idRs1, rfData1);
		idOut.rs2Data = fwdId(idRs2, rfData2);
		// a load in EX has no data yet, patch it one stage later
		idOut.fwdLoad1 = exCtrl.isLoad && exCtrl.regWen && ex.rd == idRs1;
		idOut.fwdLoad2 = exCtrl.isLoad && exCtrl.regWen && ex.rd == idRs2;
	end

	// EX
	assign exRs1 = ex.fwdLoad1 ? dbus.rdata : ex.rs1Data;
	assign exRs2 = ex.fwdLoad2 ? dbus.rdata : ex.rs2Data;
	assign exA = (exCtrl.isAuipc || exCtrl.isJal) ? ex.pc : exRs1;
	assign exB = exCtrl.needImm ? ex.imm : exRs2;

	alu aluUnit (.a(exA), .b(exB), .op(exCtrl.aluOp), .result(aluResult));

	// jumps write the link, ALU output is their target
	assign exWrData = (exCtrl.isJal || exCtrl.isJalr) ? ex.pc + `XLEN'(4) : aluResult;
	assign takeJump = (exCtrl.isBranch && aluResult[0]) || exCtrl.isJal || exCtrl.isJalr;
	assign jumpTarget = exCtrl.isBranch ? ex.pc + ex.imm : {aluResult[`XLEN-1:1], 1'b0};

	always_comb begin
		exOut.pc = ex.pc;
		exOut.aluResult = exWrData;
		exOut.storeData = exRs2;
		exOut.rd = ex.rd;
		exOut.ctrl = ex.ctrl;
	end

	// MEM, accesses stop once halting
	assign dbus.addr = mem.aluResult;
	assign dbus.wdata = mem.storeData;
	assign dbus.wen = memCtrl.memWen && !halting;
	assign dbus.ren = memCtrl.isLoad && !halting;
	assign dbus.width = memCtrl.width;
	assign dbus.isUnsigned = memCtrl.isUnsigned;
	assign memWrData = memCtrl.isLoad ? dbus.rdata : mem.aluResult;

	mmio io (
		.clk(clk), .rst(rst), .bus(dbus.dev), .swtData(swtData), .kbData(kbData),
		.kbReady(kbReady), .kbRead(kbRead), .ledData(ledData), .segData(segData)
	);

	always_comb begin
		memOut.pc = mem.pc;
		memOut.aluResult = mem.aluResult;
		memOut.loadData = dbus.rdata;
		memOut.rd = mem.rd;
		memOut.ctrl = mem.ctrl;
	end

	// WB
	assign wbWrData = wbCtrl.isLoad ? wb.loadData : wb.aluResult;
	assign pcWb = wb.pc;
	assign retire = wbValid && !halt;
	assign notImpl = wbCtrl.notImpl;

	// PC, valid bits and halt
	always_ff @(posedge clk) begin
		if (rst) begin
			pcIf <= `PC_RESET;
			idValid <= 1'b0;
			exValid <= 1'b0;
			memValid <= 1'b0;
			wbValid <= 1'b0;
			halt <= 1'b0;
		end else if (!halting) begin
			pcIf <= takeJump ? jumpTarget : pcIf + `XLEN'(4);
			// a taken jump kills what is in IF and ID
			idValid <= !takeJump;
			exValid <= idValid && !takeJump;
			memValid <= exValid;
			wbValid <= memValid;
		end else begin
			halt <= 1'b1;
		end
	end

	// stage payloads
	always_ff @(posedge clk) begin
		if (!halting) begin
			idPc <= pcIf;
			idInst <= ifInst;
			ex <= idOut;
			mem <= exOut;
			wb <= memOut;
		end
	end

	// after halt nothing retires and both PCs hold
	haltFreeze: assert property (@(posedge clk) disable iff (rst)
		halt |-> !retire && $stable(pcIf) && $stable(pcWb));
endmodule

// ==== rtl/cpuParams.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed RV32I widths and the memory map
// datapath code assumes XLEN of 32 (four byte lanes)
// I/O registers sit at word addresses above the RAM window
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath and register index widths
`define XLEN 32
`define REG_ADDR_W 5

// first fetch address
`define PC_RESET 32'h0000_0000

// depths in 32-bit words
`define ROM_WORDS 64
`define RAM_WORDS 64

// base of the 256-byte data RAM
`define RAM_BASE 32'h0000_1000

// I/O register addresses
`define LED_ADDR 32'h0000_2000
`define SEG_ADDR 32'h0000_2004
`define SWT_ADDR 32'h0000_2008
`define KB_ADDR 32'h0000_200C
`define LED_W 8

// addi x0, x0, 0
`define NOP 32'h0000_0013

`endif

// ==== rtl/decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I decode, purely combinational
// fence, ecall and csr flag notImpl and write nothing
// regWen is dropped for rd = x0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpuParams.svh"

module decoder (
	input logic [`XLEN-1:0] inst,
	output logic [`REG_ADDR_W-1:0] rd,
	output logic [`REG_ADDR_W-1:0] rs1,
	output logic [`REG_ADDR_W-1:0] rs2,
	output logic [`XLEN-1:0] imm,
	output pipePkg::ctrlT ctrl
);
	import isaPkg::*;

	opcodeT opcode;
	logic [2:0] funct3;
	logic funct7b5;

	// op-imm and op-reg share funct3 coding
	function automatic aluOpT arithOp(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0: return alt ? ALU_SUB : ALU_ADD;
			3'd1: return ALU_SLL;
			3'd2: return ALU_SLT;
			3'd3: return ALU_SLTU;
			3'd4: return ALU_XOR;
			3'd5: return alt ? ALU_SRA : ALU_SRL;
			3'd6: return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	function automatic aluOpT branchOp(input logic [2:0] f3);
		case (f3)
			3'd0: return ALU_EQ;
			3'd1: return ALU_NE;
			3'd4: return ALU_LT;
			3'd5: return ALU_GE;
			3'd6: return ALU_LTU;
			default: return ALU_GEU;
		endcase
	endfunction

	assign opcode = opcodeT'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7b5 = inst[30];

	always_comb begin
		rd = inst[11:7];
		rs1 = inst[19:15];
		rs2 = inst[24:20];
		// I-type unless a case overrides
		imm = {{20{inst[31]}}, inst[31:20]};
		ctrl = '0;
		ctrl.width = W_WORD;
		case (opcode)
			OP_LUI: begin
				// x0 + imm through the adder
				imm = {inst[31:12], 12'b0};
				rs1 = '0;
				ctrl.regWen = 1'b1;
				ctrl.needImm = 1'b1;
			end
			OP_AUIPC: begin
				imm = {inst[31:12], 12'b0};
				ctrl.regWen = 1'b1;
				ctrl.needImm = 1'b1;
				ctrl.isAuipc = 1'b1;
			end
			OP_JAL: begin
				imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
				ctrl.regWen = 1'b1;
				ctrl.needImm = 1'b1;
				ctrl.isJal = 1'b1;
			end
			OP_JALR: begin
				ctrl.regWen = 1'b1;
				ctrl.needImm = 1'b1;
				ctrl.isJalr = 1'b1;
			end
			OP_BRANCH: begin
				imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
				ctrl.aluOp = branchOp(funct3);
				ctrl.isBranch = 1'b1;
			end
			OP_LOAD: begin
				ctrl.width = widthT'(funct3[1:0]);
				ctrl.isUnsigned = funct3[2];
				ctrl.regWen = 1'b1;
				ctrl.isLoad = 1'b1;
				ctrl.needImm = 1'b1;
			end
			OP_STORE: begin
				imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
				ctrl.width = widthT'(funct3[1:0]);
				ctrl.memWen = 1'b1;
				ctrl.needImm = 1'b1;
			end
			OP_IMM: begin
				// funct7 only matters for the right shift here
				ctrl.aluOp = arithOp(funct3, funct3 == 3'd5 && funct7b5);
				ctrl.regWen = 1'b1;
				ctrl.needImm = 1'b1;
			end
			OP_REG: begin
				ctrl.aluOp = arithOp(funct3, funct7b5);
				ctrl.regWen = 1'b1;
			end
			OP_SYSTEM: begin
				// ebreak only, ecall and csr fall to notImpl
				ctrl.isEbreak = inst[31:20] == 12'h001 && funct3 == 3'd0;
				ctrl.notImpl = !ctrl.isEbreak;
			end
			default: begin
				ctrl.notImpl = 1'b1;
			end
		endcase
		if (rd == '0)
			ctrl.regWen = 1'b0;
	end

	// every opcode path keeps the two write enables exclusive
	always_comb begin
		writeExclusive: assert (!(ctrl.memWen && ctrl.regWen))
			else $error("decoder set memWen and regWen together");
	end
endmodule

// ==== rtl/instRom.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program ROM, read from prog.hex at start
// words past the image or the depth read as NOP
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpuParams.svh"

module instRom (
	input logic [`XLEN-1:0] pc,
	output logic [`XLEN-1:0] inst
);
	localparam int RomAw = $clog2(`ROM_WORDS);

	logic [`XLEN-1:0] rom [`ROM_WORDS];
	logic [`XLEN-3:0] wordIdx;

	// pad with NOP so a short image stays harmless
	initial begin
		for (int i = 0; i < `ROM_WORDS; i++)
			rom[i] = `NOP;
		$readmemh("prog.hex", rom);
	end

	// byte PC to word index
	assign wordIdx = pc[`XLEN-1:2];
	assign inst = (wordIdx < `ROM_WORDS) ? rom[wordIdx[RomAw-1:0]] : `NOP;
endmodule

// ==== rtl/isaPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I encodings used by the decoder, ALU and I/O
// only the opcodes of the integer subset are listed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package isaPkg;

	// major opcodes, inst[6:0]
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011,
		OP_FENCE  = 7'b0001111,
		OP_SYSTEM = 7'b1110011
	} opcodeT;

	// arithmetic first, then the branch compares
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
		ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
		ALU_OR, ALU_AND, ALU_EQ, ALU_NE,
		ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
	} aluOpT;

	// same coding as funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		W_BYTE = 2'b00,
		W_HALF = 2'b01,
		W_WORD = 2'b10
	} widthT;

endpackage

// ==== rtl/memBus.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one data access from the MEM stage to the I/O block
// rdata is combinational, writes land on the next edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpuParams.svh"

interface memBus;
	logic [`XLEN-1:0] addr;
	logic [`XLEN-1:0] wdata;
	logic wen;
	logic ren;
	isaPkg::widthT width;
	// zero-extend instead of sign-extend
	logic isUnsigned;
	// already extended to XLEN
	logic [`XLEN-1:0] rdata;

	modport core (output addr, wdata, wen, ren, width, isUnsigned, input rdata);
	modport dev (input addr, wdata, wen, ren, width, isUnsigned, output rdata);
endinterface

// ==== rtl/mmio.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data RAM and I/O registers behind one address map
// LED and SEG take the low bits of wdata, lanes ignored
// unmapped reads return zero, unmapped writes are dropped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpuParams.svh"

module mmio (
	input logic clk,
	input logic rst,
	memBus.dev bus,
	input logic [7:0] swtData,
	input logic [7:0] kbData,
	input logic kbReady,
	output logic kbRead,
	output logic [`LED_W-1:0] ledData,
	output logic [`XLEN-1:0] segData
);
	import isaPkg::*;

	localparam int RamAw = $clog2(`RAM_WORDS);
	localparam logic [`XLEN-1:0] RamBase = `RAM_BASE;

	logic [`XLEN-1:0] ram [`RAM_WORDS];
	logic [`XLEN-1:0] wordAddr;
	logic [`XLEN-1:0] rawWord;
	logic [`XLEN-1:0] shifted;
	logic [`XLEN-1:0] laneData;
	logic [RamAw-1:0] ramIdx;
	logic [3:0] laneMask;
	logic [1:0] byteOff;
	logic isRam;
	logic isLed;
	logic isSeg;
	logic isSwt;
	logic isKb;

	// address decode
	assign wordAddr = {bus.addr[`XLEN-1:2], 2'b00};
	assign byteOff = bus.addr[1:0];
	assign ramIdx = bus.addr[RamAw+1:2];
	assign isRam = bus.addr[`XLEN-1:RamAw+2] == RamBase[`XLEN-1:RamAw+2];
	assign isLed = wordAddr == `LED_ADDR;
	assign isSeg = wordAddr == `SEG_ADDR;
	assign isSwt = wordAddr == `SWT_ADDR;
	assign isKb = wordAddr == `KB_ADDR;

	// replicate store data over all lanes, mask picks the live ones
	always_comb begin
		case (bus.width)
			W_BYTE: begin
				laneMask = 4'b0001 << byteOff;
				laneData = {4{bus.wdata[7:0]}};
			end
			W_HALF: begin
				laneMask = 4'b0011 << byteOff;
				laneData = {2{bus.wdata[15:0]}};
			end
			default: begin
				laneMask = 4'b1111;
				laneData = bus.wdata;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (bus.wen && isRam) begin
			for (int i = 0; i < 4; i++)
				if (laneMask[i])
					ram[ramIdx][8*i +: 8] <= laneData[8*i +: 8];
		end
	end

	// output registers, visible the cycle after the store
	always_ff @(posedge clk) begin
		if (rst) begin
			ledData <= '0;
			segData <= '0;
		end else if (bus.wen) begin
			if (isLed)
				ledData <= bus.wdata[`LED_W-1:0];
			if (isSeg)
				segData <= bus.wdata;
		end
	end

	// read mux, then align and extend
	always_comb begin
		rawWord = '0;
		if (isRam)
			rawWord = ram[ramIdx];
		else if (isSwt)
			rawWord = `XLEN'(swtData);
		else if (isKb)
			rawWord = `XLEN'({kbReady, kbData});
		else if (isLed)
			rawWord = `XLEN'(ledData);
		else if (isSeg)
			rawWord = segData;
		shifted = rawWord >> {byteOff, 3'b000};
		case (bus.width)
			W_BYTE: bus.rdata = bus.isUnsigned ? `XLEN'(shifted[7:0])
				: `XLEN'($signed(shifted[7:0]));
			W_HALF: bus.rdata = bus.isUnsigned ? `XLEN'(shifted[15:0])
				: `XLEN'($signed(shifted[15:0]));
			default: bus.rdata = shifted;
		endcase
	end

	// consume a key only when one is waiting
	assign kbRead = bus.ren && isKb && kbReady;

	// the core never issues a load and a store in one MEM cycle
	accessExclusive: assert property (@(posedge clk) disable iff (rst)
		!(bus.wen && bus.ren));
endmodule

// ==== rtl/pipePkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control word and stage register payloads
// valid bits live beside these, not inside
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpuParams.svh"

package pipePkg;

	// decoded control, all flags low means bubble
	typedef struct packed {
		isaPkg::aluOpT aluOp;
		isaPkg::widthT width;
		logic regWen;
		logic memWen;
		logic isLoad;
		logic isUnsigned;
		logic isBranch;
		logic isJal;
		logic isJalr;
		logic isAuipc;
		logic needImm;
		logic isEbreak;
		logic notImpl;
	} ctrlT;

	// ID/EX contents
	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] imm;
		logic [`XLEN-1:0] rs1Data;
		logic [`XLEN-1:0] rs2Data;
		logic [`REG_ADDR_W-1:0] rd;
		ctrlT ctrl;
		// operand still owed by a load now in MEM
		logic fwdLoad1;
		logic fwdLoad2;
	} exPayloadT;

	// EX/MEM contents
	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] aluResult;
		logic [`XLEN-1:0] storeData;
		logic [`REG_ADDR_W-1:0] rd;
		ctrlT ctrl;
	} memPayloadT;

	// MEM/WB contents
	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] aluResult;
		logic [`XLEN-1:0] loadData;
		logic [`REG_ADDR_W-1:0] rd;
		ctrlT ctrl;
	} wbPayloadT;

endpackage

// ==== rtl/regFile.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 31 registers, x0 reads zero
// a write in the read cycle is seen at once
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpuParams.svh"

module regFile (
	input logic clk,
	input logic rst,
	input logic wen,
	input logic [`REG_ADDR_W-1:0] rd,
	input logic [`REG_ADDR_W-1:0] rs1,
	input logic [`REG_ADDR_W-1:0] rs2,
	input logic [`XLEN-1:0] wdata,
	output logic [`XLEN-1:0] rdata1,
	output logic [`XLEN-1:0] rdata2
);
	logic [`XLEN-1:0] regs [1:31];

	// write-through so WB needs no forward path of its own
	function automatic logic [`XLEN-1:0] readPort(input logic [`REG_ADDR_W-1:0] idx);
		if (idx == '0)
			return '0;
		if (wen && idx == rd)
			return wdata;
		return regs[idx];
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wen && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	always_comb begin
		rdata1 = readPort(rs1);
		rdata2 = readPort(rs2);
	end
endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cpu testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module cpuTb -o simv \
	> build.log 2>&1 \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| echo "build or simulation ended with an error, see build.log and sim.log"
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verification/cpuTb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// runs prog.hex on the core and checks by assertions
// expects prog.hex in the working directory
// branch PCs below follow the layout of prog.hex
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpuParams.svh"

module cpuTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ResetCycles = 8;
	// late enough for the poll loop to spin a few times
	localparam int KbReadyCycle = 60;
	// about 80 cycles of program and polling with wide margin
	localparam int TimeoutCycles = 400;

	// x6 = (((5 + 7) << 2) - 5) ^ (5 + 7) = 39
	localparam logic [31:0] ExpChain = 32'd39;
	// loop adds 9 three times
	localparam logic [31:0] ExpLoop = 32'd27;
	// x4 of the chain is only stored by squashed slots
	localparam logic [31:0] PoisonVal = 32'd48;
	localparam logic [31:0] LoopBodyPc = 32'h24;
	localparam logic [31:0] LoopBrPc = 32'h2C;
	localparam logic [31:0] SkipBrPc = 32'h34;
	localparam logic [31:0] PollBrPc = 32'h58;

	logic clk;
	logic rst;
	logic [7:0] swtData;
	logic [7:0] kbData;
	logic kbReady;
	logic [31:0] pcIf;
	logic [31:0] pcWb;
	logic retire;
	logic halt;
	logic notImpl;
	logic kbRead;
	logic [`LED_W-1:0] ledData;
	logic [31:0] segData;

	int seed = 5080;
	int cycle = 0;
	int segChanges = 0;
	int loopBrSeen = 0;
	int loopBodyCount = 0;
	logic [31:0] randWord;
	logic [7:0] swtByte;
	logic [7:0] kbByte;
	logic [31:0] prevSeg;
	logic [`LED_W-1:0] prevLed;
	logic [2:0] readyHist;
	logic segChanged;
	logic ledChanged;
	logic takenRetire;

	cpu DUT (
		.clk(clk), .rst(rst), .swtData(swtData), .kbData(kbData), .kbReady(kbReady),
		.pcIf(pcIf), .pcWb(pcWb), .retire(retire), .halt(halt), .notImpl(notImpl),
		.kbRead(kbRead), .ledData(ledData), .segData(segData)
	);

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic valueFail(input string name, input logic [31:0] got, input logic [31:0] exp);
		abortRun($sformatf("FAIL %s: got 0x%08h expected 0x%08h", name, got, exp));
	endtask

	// expected SEG value for each store that changes it in program order
	function automatic logic [31:0] expSeg(input int idx);
		case (idx)
			0: return ExpChain;
			1: return ExpLoop;
			// lb sign-extends the switch byte
			2: return 32'hFFFF_FF00 | {24'h0, swtByte};
			default: return {24'h0, kbByte};
		endcase
	endfunction

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// posedge count that also drives the timeout
	always @(posedge clk) begin
		cycle <= cycle + 1;
		prevSeg <= segData;
		prevLed <= ledData;
		// kbReady as seen by the poll load three WB cycles before its branch
		readyHist <= {readyHist[1:0], kbReady};
		if (segChanged)
			segChanges <= segChanges + 1;
		if (retire && pcWb == LoopBrPc)
			loopBrSeen <= loopBrSeen + 1;
		if (retire && pcWb == LoopBodyPc)
			loopBodyCount <= loopBodyCount + 1;
	end

	assign segChanged = cycle > ResetCycles && segData != prevSeg;
	assign ledChanged = cycle > ResetCycles && ledData != prevLed;
	// skip branch always taken and loop branch taken on its first two passes
	// poll branch taken while the polled load saw no key
	assign takenRetire = retire && (pcWb == SkipBrPc
		|| (pcWb == LoopBrPc && loopBrSeen < 2)
		|| (pcWb == PollBrPc && !readyHist[2]));

	// reset values from the second reset edge to the cycle after release
	resetPc: assert property (@(posedge clk)
		(cycle >= 1 && cycle <= ResetCycles) |-> pcIf == `PC_RESET)
		else valueFail("pcIf", pcIf, `PC_RESET);
	resetOut: assert property (@(posedge clk)
		(cycle >= 1 && cycle <= ResetCycles) |-> ledData == '0 && segData == '0)
		else abortRun("LED or SEG output not zero around reset");
	resetFlags: assert property (@(posedge clk)
		(cycle >= 1 && cycle <= ResetCycles) |-> !retire && !halt && !notImpl && !kbRead)
		else abortRun("a status output was high around reset");

	// each SEG change must be the next expected value
	segValue: assert property (@(posedge clk) segChanged |-> segData == expSeg(segChanges))
		else valueFail("segData", segData, expSeg(segChanges));
	segCount: assert property (@(posedge clk) segChanged |-> segChanges < 4)
		else abortRun("segData changed more often than the program stores to it");
	noPoison: assert property (@(posedge clk) (cycle >= 1) |-> segData != PoisonVal)
		else valueFail("segData", segData, ExpLoop);

	// two bubbles behind every taken branch
	squashBubbles: assert property (@(posedge clk)
		($past(takenRetire) || $past(takenRetire, 2)) |-> !retire)
		else abortRun("an instruction retired in a slot a taken branch should have squashed");

	ledValue: assert property (@(posedge clk) ledChanged |-> ledData == swtByte)
		else valueFail("ledData", 32'(ledData), 32'(swtByte));

	// keyboard only consumed while a key is waiting
	kbGuard: assert property (@(posedge clk) (cycle >= 1 && !kbReady) |-> !kbRead)
		else abortRun("kbRead pulsed while kbReady was low");

	noNotImpl: assert property (@(posedge clk) (cycle >= 1) |-> !notImpl)
		else abortRun("notImpl rose on the test program");

	// after halt everything holds
	haltSticky: assert property (@(posedge clk) (cycle >= 2 && $past(halt)) |-> halt)
		else abortRun("halt dropped after rising");
	haltFrozen: assert property (@(posedge clk) (cycle >= 2 && halt && $past(halt)) |->
		!retire && $stable(pcWb) && $stable(ledData) && $stable(segData))
		else abortRun("pipeline or outputs moved after halt");

	// stimulus driven on the falling edge
	initial begin
		rst = 1'b1;
		kbReady = 1'b0;
		randWord = $random(seed);
		// top bit set so the signed load shows its extension
		swtByte = randWord[7:0] | 8'h80;
		randWord = $random(seed);
		kbByte = randWord[7:0];
		swtData = swtByte;
		kbData = kbByte;
		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (cycle < KbReadyCycle)
			@(negedge clk);
		kbReady = 1'b1;
	end

	// end of run once halt has been stable a while
	initial begin
		wait (halt === 1'b1);
		repeat (8) @(negedge clk);
		if (segChanges == 4 && ledData == swtByte && loopBodyCount == 3) begin
			$display("all tests passed");
			$finish;
		end else begin
			abortRun("halted with wrong SEG history, LED value or loop count");
		end
	end

	initial begin
		while (cycle < TimeoutCycles)
			@(posedge clk);
		abortRun("timeout, halt did not rise within the cycle limit");
	end
endmodule
